// File: common/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// word address and data widths
`define ADDR_W 36
`define WORD_W 32

// line geometry, direct mapped with 64 lines of 4 words
`define WORDS_PER_LINE 4
`define INDEX_W 6
`define NUM_LINES (1 << `INDEX_W)

// address split: word offset, set index, then the tag in the upper bits
`define OFFSET_LSB 0
`define OFFSET_MSB 1
`define INDEX_LSB (`OFFSET_MSB + 1)
`define INDEX_MSB (`INDEX_LSB + `INDEX_W - 1)
`define TAG_LSB (`INDEX_MSB + 1)
`define TAG_MSB (`ADDR_W - 1)
`define TAG_W (`ADDR_W - `TAG_LSB)

`endif

// File: common/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

  // one data word as seen by the processor
  typedef logic [`WORD_W-1:0] word_t;

  // a full line, word 0 sits in the lowest bits
  typedef logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] line_t;

  // word address, the offset field picks the word inside a line
  typedef logic [`ADDR_W-1:0] addr_t;

  typedef logic [`TAG_W-1:0] tag_t;

  typedef logic [`INDEX_W-1:0] index_t;

  // metadata kept per line in the tag array
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

endpackage

// File: common/ring_pkg.sv
package ring_pkg;

  // packet type carried in the shared ring slot
  // an empty slot is free for any requester to take
  typedef enum logic [2:0] {
    pkt_empty      = 3'b000,
    // evicted line going out to memory, answered by an ack
    pkt_write_line = 3'b001,
    // line fill request, answered by a data packet
    pkt_read_line  = 3'b011,
    // memory side responses
    pkt_ack        = 3'b101,
    pkt_data       = 3'b110
  } pkt_type_e;

endpackage

// File: dcache/cache_ctrl.sv
`timescale 1ns/10ps
`include "cache_params.svh"

module cache_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  r,
  input  logic                  w,
  input  cache_pkg::addr_t      addr,
  input  cache_pkg::tag_entry_t tag_entry,
  input  ring_pkg::pkt_type_e   mem_type_in,
  output logic                  stall,
  output logic                  tag_wr_en,
  output logic                  data_wr_en,
  output cache_pkg::tag_entry_t new_entry,
  output logic                  evict_capture,
  output logic                  use_fill,
  output logic                  overwrite,
  output ring_pkg::pkt_type_e   mem_type_out,
  output logic                  mem_addr_sel
);

  import cache_pkg::*;
  import ring_pkg::*;

  typedef enum logic [2:0] {
    idle,
    send_write_back,
    wait_ack,
    send_fill_req,
    wait_fill
  } state_t;

  state_t state, next_state;
  tag_t   req_tag;
  logic   req;
  logic   hit;

  assign req_tag = addr[`TAG_MSB:`TAG_LSB];
  assign req = r | w;
  assign hit = tag_entry.valid && (tag_entry.tag == req_tag);

  always_comb begin
    next_state = state;
    stall = 1'b0;
    tag_wr_en = 1'b0;
    data_wr_en = 1'b0;
    new_entry = '{valid: 1'b1, dirty: 1'b0, tag: req_tag};
    evict_capture = 1'b0;
    use_fill = 1'b0;
    overwrite = 1'b0;
    mem_type_out = pkt_empty;
    mem_addr_sel = 1'b0;

    case (state)
      // hits of both kinds complete here with no added cycles
      idle: begin
        if (req && hit) begin
          if (w) begin
            data_wr_en = 1'b1;
            tag_wr_en = 1'b1;
            new_entry.dirty = 1'b1;
          end
        end else if (req) begin
          stall = 1'b1;
          if (tag_entry.valid && tag_entry.dirty) begin
            evict_capture = 1'b1;
            next_state = send_write_back;
          end else begin
            next_state = send_fill_req;
          end
        end
      end

      // victim line goes out as soon as the slot is free
      send_write_back: begin
        stall = 1'b1;
        mem_type_out = pkt_write_line;
        mem_addr_sel = 1'b1;
        if (mem_type_in == pkt_empty) begin
          overwrite = 1'b1;
          next_state = wait_ack;
        end
      end

      // consuming the ack also empties the slot again
      wait_ack: begin
        stall = 1'b1;
        if (mem_type_in == pkt_ack) begin
          overwrite = 1'b1;
          next_state = send_fill_req;
        end
      end

      send_fill_req: begin
        stall = 1'b1;
        mem_type_out = pkt_read_line;
        if (mem_type_in == pkt_empty) begin
          overwrite = 1'b1;
          next_state = wait_fill;
        end
      end

      // fill line and clean tag are written on the same edge that frees the slot,
      // the request then hits in idle one cycle later
      wait_fill: begin
        stall = 1'b1;
        if (mem_type_in == pkt_data) begin
          overwrite = 1'b1;
          tag_wr_en = 1'b1;
          data_wr_en = 1'b1;
          use_fill = 1'b1;
          next_state = idle;
        end
      end

      default: begin
        next_state = idle;
      end
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  // a packet just placed in the slot is left alone until memory answers it
  a_no_foreign_overwrite: assert property (@(posedge clk) disable iff (rst)
    (overwrite && (mem_type_out != pkt_empty)) |=> !overwrite);

  // a miss releases the processor only once the refilled line hits
  a_stall_ends_on_refill_hit: assert property (@(posedge clk) disable iff (rst)
    $fell(stall) |-> (hit && $past(use_fill)));

endmodule

// File: dcache/cache_datapath.sv
`timescale 1ns/10ps
`include "cache_params.svh"

module cache_datapath (
  input  logic              clk,
  input  logic              rst,
  input  cache_pkg::addr_t  addr,
  input  cache_pkg::word_t  w_data,
  input  cache_pkg::line_t  rd_line,
  input  cache_pkg::tag_t   rd_tag,
  input  cache_pkg::line_t  fill_line,
  input  logic              evict_capture,
  input  logic              use_fill,
  output cache_pkg::addr_t  evict_addr,
  output cache_pkg::line_t  wr_line,
  output cache_pkg::word_t  data_out
);

  import cache_pkg::*;

  logic [`OFFSET_MSB-`OFFSET_LSB:0] word_sel;
  addr_t victim_addr;
  line_t merged_line;

  assign word_sel = addr[`OFFSET_MSB:`OFFSET_LSB];

  // the victim lives at the same index under the stored tag, word 0 of the line
  assign victim_addr = {rd_tag, addr[`INDEX_MSB:`INDEX_LSB], {(`OFFSET_MSB + 1){1'b0}}};

  // held for the whole write back since the ring slot may be busy for a while
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      evict_addr <= '0;
    end else if (evict_capture) begin
      evict_addr <= victim_addr;
    end
  end

  // read modify write of one word into the current line
  always_comb begin
    merged_line = rd_line;
    merged_line[word_sel] = w_data;
  end

  // a fill replaces the whole line, otherwise this is a word write hit
  assign wr_line = use_fill ? fill_line : merged_line;

  assign data_out = rd_line[word_sel];

endmodule

// File: dcache/dcache_top.sv
`timescale 1ns/10ps
`include "cache_params.svh"

module dcache_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                r,
  input  logic                w,
  input  cache_pkg::addr_t    addr,
  input  cache_pkg::word_t    w_data,
  input  ring_pkg::pkt_type_e mem_type_in,
  input  cache_pkg::addr_t    mem_addr_in,
  input  cache_pkg::line_t    mem_data_in,
  output cache_pkg::word_t    data_out,
  output logic                stall,
  output logic                overwrite,
  output ring_pkg::pkt_type_e mem_type_out,
  output cache_pkg::addr_t    mem_addr_out,
  output cache_pkg::line_t    mem_data_out
);

  import cache_pkg::*;

  index_t     index;
  tag_entry_t rd_tag_entry;
  tag_entry_t new_entry;
  line_t      rd_line;
  line_t      wr_line;
  addr_t      evict_addr;
  logic       tag_wr_en;
  logic       data_wr_en;
  logic       evict_capture;
  logic       use_fill;
  logic       mem_addr_sel;

  // the request is held through a miss, so one index serves reads and writes
  assign index = addr[`INDEX_MSB:`INDEX_LSB];

  // read requests use the request address, line writes the captured victim address
  assign mem_addr_out = mem_addr_sel ? evict_addr : addr;
  assign mem_data_out = rd_line;

  cache_ctrl ctrl_i (
    .clk           (clk),
    .rst           (rst),
    .r             (r),
    .w             (w),
    .addr          (addr),
    .tag_entry     (rd_tag_entry),
    .mem_type_in   (mem_type_in),
    .stall         (stall),
    .tag_wr_en     (tag_wr_en),
    .data_wr_en    (data_wr_en),
    .new_entry     (new_entry),
    .evict_capture (evict_capture),
    .use_fill      (use_fill),
    .overwrite     (overwrite),
    .mem_type_out  (mem_type_out),
    .mem_addr_sel  (mem_addr_sel)
  );

  cache_datapath datapath_i (
    .clk           (clk),
    .rst           (rst),
    .addr          (addr),
    .w_data        (w_data),
    .rd_line       (rd_line),
    .rd_tag        (rd_tag_entry.tag),
    .fill_line     (mem_data_in),
    .evict_capture (evict_capture),
    .use_fill      (use_fill),
    .evict_addr    (evict_addr),
    .wr_line       (wr_line),
    .data_out      (data_out)
  );

  cache_array #(.entry_t(tag_entry_t), .DEPTH(`NUM_LINES)) tag_array_i (
    .clk      (clk),
    .rst      (rst),
    .rd_index (index),
    .wr_index (index),
    .wr_en    (tag_wr_en),
    .wr_entry (new_entry),
    .rd_entry (rd_tag_entry)
  );

  cache_array #(.entry_t(line_t), .DEPTH(`NUM_LINES)) data_array_i (
    .clk      (clk),
    .rst      (rst),
    .rd_index (index),
    .wr_index (index),
    .wr_en    (data_wr_en),
    .wr_entry (wr_line),
    .rd_entry (rd_line)
  );

endmodule

// File: design/cache_array.sv
`timescale 1ns/10ps
`include "cache_params.svh"

module cache_array #(
  parameter type entry_t = logic,
  parameter int DEPTH = `NUM_LINES
) (
  input  logic              clk,
  input  logic              rst,
  input  cache_pkg::index_t rd_index,
  input  cache_pkg::index_t wr_index,
  input  logic              wr_en,
  input  entry_t            wr_entry,
  output entry_t            rd_entry
);

  entry_t mem [DEPTH];

  // cleared on reset so that every tag starts out invalid
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_index] <= wr_entry;
    end
  end

  // read is combinational so a hit resolves in the request cycle
  assign rd_entry = mem[rd_index];

  a_wr_index_known: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> !$isunknown(wr_index));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the data cache testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module dcache_tb -o dcache_sim

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/dcache_sim

// File: verification/dcache_tb.sv
`timescale 1ns/10ps
`include "cache_params.svh"

module dcache_tb;

  import cache_pkg::*;
  import ring_pkg::*;

  typedef struct {
    string name;
    logic  is_write;
    addr_t addr;
    word_t wdata;
    int    busy;
    int    exp_reads;
    int    exp_wbs;
  } row_t;

  localparam int PERIOD = 8;
  localparam int NUM_ROWS = 13;

  // name, write, address, write data, busy cycles, expected line reads, expected write backs
  // index 1 and index 8 each see a dirty eviction
  row_t rows [NUM_ROWS] = '{
    '{"cold_read",    1'b0, 36'h0_0000_0105, 32'h0000_0000, 0, 1, 0},
    '{"read_hit",     1'b0, 36'h0_0000_0107, 32'h0000_0000, 0, 0, 0},
    '{"write_hit",    1'b1, 36'h0_0000_0106, 32'hdead_beef, 0, 0, 0},
    '{"read_word0",   1'b0, 36'h0_0000_0104, 32'h0000_0000, 0, 0, 0},
    '{"read_word1",   1'b0, 36'h0_0000_0105, 32'h0000_0000, 0, 0, 0},
    '{"read_word2",   1'b0, 36'h0_0000_0106, 32'h0000_0000, 0, 0, 0},
    '{"read_word3",   1'b0, 36'h0_0000_0107, 32'h0000_0000, 0, 0, 0},
    '{"evict_dirty",  1'b0, 36'h0_0000_0204, 32'h0000_0000, 2, 1, 1},
    '{"busy_fill",    1'b0, 36'h3_0000_0013, 32'h0000_0000, 3, 1, 0},
    '{"write_miss",   1'b1, 36'h0_5000_0020, 32'h1234_5678, 5, 1, 0},
    '{"read_back",    1'b0, 36'h0_5000_0020, 32'h0000_0000, 0, 0, 0},
    '{"evict_busy",   1'b0, 36'h0_6000_0021, 32'h0000_0000, 4, 1, 1},
    '{"read_evicted", 1'b0, 36'h0_5000_0020, 32'h0000_0000, 1, 1, 0}
  };

  logic      clk;
  logic      rst;
  logic      r;
  logic      w;
  addr_t     addr;
  word_t     w_data;
  word_t     data_out;
  logic      stall;
  logic      overwrite;
  pkt_type_e mem_type_in;
  pkt_type_e mem_type_out;
  addr_t     mem_addr_in;
  addr_t     mem_addr_out;
  line_t     mem_data_in;
  line_t     mem_data_out;
  int        busy_cycles;
  int        read_reqs;
  int        write_reqs;
  logic      wb_seen;
  logic      bad_overwrite;
  addr_t     wb_addr;
  addr_t     last_read_addr;
  line_t     wb_line;
  string     cur_name = "reset";

  // memory contents as the processor should see them
  word_t shadow [addr_t];

  tb_clock #(.HALF_PERIOD(PERIOD / 2)) clock_i (.clk(clk));

  dcache_top dcache_top_i (
    .clk          (clk),
    .rst          (rst),
    .r            (r),
    .w            (w),
    .addr         (addr),
    .w_data       (w_data),
    .mem_type_in  (mem_type_in),
    .mem_addr_in  (mem_addr_in),
    .mem_data_in  (mem_data_in),
    .data_out     (data_out),
    .stall        (stall),
    .overwrite    (overwrite),
    .mem_type_out (mem_type_out),
    .mem_addr_out (mem_addr_out),
    .mem_data_out (mem_data_out)
  );

  ring_mem_model mem_i (
    .clk            (clk),
    .rst            (rst),
    .overwrite      (overwrite),
    .mem_type_out   (mem_type_out),
    .mem_addr_out   (mem_addr_out),
    .mem_data_out   (mem_data_out),
    .busy_cycles    (busy_cycles),
    .mem_type_in    (mem_type_in),
    .mem_addr_in    (mem_addr_in),
    .mem_data_in    (mem_data_in),
    .wb_seen        (wb_seen),
    .wb_addr        (wb_addr),
    .wb_line        (wb_line),
    .last_read_addr (last_read_addr),
    .read_reqs      (read_reqs),
    .write_reqs     (write_reqs),
    .bad_overwrite  (bad_overwrite)
  );

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_line(string name, line_t exp, line_t act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_addr(string name, addr_t exp, addr_t act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_pkt(string name, pkt_type_e exp, pkt_type_e act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected %s actual %s", name, exp.name(),
                               act.name()));
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      report_failure($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  function automatic addr_t line_base(addr_t a);
    return {a[`ADDR_W-1:`OFFSET_MSB+1], {(`OFFSET_MSB + 1){1'b0}}};
  endfunction

  // a word never written reads back as its own address
  function automatic word_t shadow_word(addr_t a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return word_t'(a);
  endfunction

  function automatic line_t shadow_line(addr_t base);
    line_t l;
    for (int i = 0; i < `WORDS_PER_LINE; i++) begin
      l[i] = shadow_word(base + addr_t'(i));
    end
    return l;
  endfunction

  always @(negedge clk) begin
    if (wb_seen) begin
      check_line(cur_name, shadow_line(wb_addr), wb_line);
    end
    if (bad_overwrite) begin
      report_failure("the cache overwrote the ring slot while foreign traffic held it");
    end
  end

  // each row may need a write back and a fill, each with delay, busy cycles and handshakes
  initial begin
    int budget;
    budget = 8 + 40;
    foreach (rows[i]) begin
      budget += 2 * (4 + rows[i].busy + 4) + 2;
    end
    #(budget * PERIOD);
    report_failure("timeout, the cache did not finish its requests in time");
  end

  initial begin
    int    reads0;
    int    wbs0;
    int    cycles;
    word_t got;
    void'($urandom(9));
    rst = 1'b1;
    r = 1'b0;
    w = 1'b0;
    addr = '0;
    w_data = '0;
    busy_cycles = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_flag("reset stall", 1'b0, stall);
    check_flag("reset overwrite", 1'b0, overwrite);
    check_pkt("reset mem_type_out", pkt_empty, mem_type_out);

    foreach (rows[i]) begin
      @(negedge clk);
      cur_name = rows[i].name;
      r = !rows[i].is_write;
      w = rows[i].is_write;
      addr = rows[i].addr;
      w_data = rows[i].wdata;
      busy_cycles = rows[i].busy;
      reads0 = read_reqs;
      wbs0 = write_reqs;
      cycles = 0;
      // stall and data_out are read a quarter period before each rising edge, where they
      // have settled; the first cycle with stall low completes the request at its edge
      do begin
        if (cycles > 0) begin
          @(negedge clk);
        end
        #(PERIOD / 4);
        cycles++;
      end while (stall);
      got = data_out;
      check_flag({cur_name, " overwrite"}, 1'b0, overwrite);
      @(negedge clk);
      r = 1'b0;
      w = 1'b0;
      if (rows[i].is_write) begin
        shadow[rows[i].addr] = rows[i].wdata;
      end else begin
        check_word(cur_name, shadow_word(rows[i].addr), got);
      end
      check_count({cur_name, " line reads"}, rows[i].exp_reads, read_reqs - reads0);
      check_count({cur_name, " write backs"}, rows[i].exp_wbs, write_reqs - wbs0);
      if (rows[i].exp_reads > 0) begin
        check_addr({cur_name, " read line"}, line_base(rows[i].addr),
                   line_base(last_read_addr));
      end else begin
        check_count({cur_name, " hit cycles"}, 1, cycles);
      end
    end

    $display("Test OK");
    $finish;
  end

endmodule

// File: verification/ring_mem_model.sv
`timescale 1ns/10ps
`include "cache_params.svh"

module ring_mem_model (
  input  logic                clk,
  input  logic                rst,
  input  logic                overwrite,
  input  ring_pkg::pkt_type_e mem_type_out,
  input  cache_pkg::addr_t    mem_addr_out,
  input  cache_pkg::line_t    mem_data_out,
  input  int                  busy_cycles,
  output ring_pkg::pkt_type_e mem_type_in,
  output cache_pkg::addr_t    mem_addr_in,
  output cache_pkg::line_t    mem_data_in,
  output logic                wb_seen,
  output cache_pkg::addr_t    wb_addr,
  output cache_pkg::line_t    wb_line,
  output cache_pkg::addr_t    last_read_addr,
  output int                  read_reqs,
  output int                  write_reqs,
  output logic                bad_overwrite
);

  import cache_pkg::*;
  import ring_pkg::*;

  // lines written back so far, keyed by the address of word 0
  line_t     lines [addr_t];
  addr_t     out_base;
  addr_t     req_addr;
  pkt_type_e resp_type;
  logic      pending;
  int        delay;
  int        busy;

  assign out_base = {mem_addr_out[`ADDR_W-1:`OFFSET_MSB+1], {(`OFFSET_MSB + 1){1'b0}}};

  // memory never written holds its own word address in every word
  function automatic line_t backing_line(addr_t base);
    line_t l;
    if (lines.exists(base)) begin
      return lines[base];
    end
    for (int i = 0; i < `WORDS_PER_LINE; i++) begin
      l[i] = word_t'(base + addr_t'(i));
    end
    return l;
  endfunction

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      mem_type_in <= pkt_empty;
      mem_addr_in <= '0;
      mem_data_in <= '0;
      wb_seen <= 1'b0;
      wb_addr <= '0;
      wb_line <= '0;
      last_read_addr <= '0;
      read_reqs <= 0;
      write_reqs <= 0;
      bad_overwrite <= 1'b0;
      req_addr <= '0;
      resp_type <= pkt_empty;
      pending <= 1'b0;
      delay <= 0;
      busy <= 0;
    end else begin
      wb_seen <= 1'b0;
      // only an empty slot or a response may be taken over by the cache
      bad_overwrite <= overwrite && !(mem_type_in inside {pkt_empty, pkt_ack, pkt_data});
      if (overwrite) begin
        mem_type_in <= mem_type_out;
        mem_addr_in <= mem_addr_out;
        mem_data_in <= mem_data_out;
        if (mem_type_out != pkt_empty) begin
          pending <= 1'b1;
          delay <= int'($urandom_range(4, 1));
          busy <= busy_cycles;
          req_addr <= out_base;
          resp_type <= (mem_type_out == pkt_write_line) ? pkt_ack : pkt_data;
        end
        if (mem_type_out == pkt_write_line) begin
          lines[out_base] = mem_data_out;
          write_reqs <= write_reqs + 1;
          wb_seen <= 1'b1;
          wb_addr <= out_base;
          wb_line <= mem_data_out;
        end else if (mem_type_out == pkt_read_line) begin
          read_reqs <= read_reqs + 1;
          last_read_addr <= mem_addr_out;
        end
      end else if (pending) begin
        if (delay > 1) begin
          delay <= delay - 1;
        end else if (busy > 0) begin
          // another ring node passes through the slot before the answer
          busy <= busy - 1;
          mem_type_in <= pkt_write_line;
          mem_addr_in <= ~req_addr;
        end else begin
          pending <= 1'b0;
          mem_type_in <= resp_type;
          mem_addr_in <= req_addr;
          mem_data_in <= backing_line(req_addr);
        end
      end
    end
  end

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
  parameter int HALF_PERIOD = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

endmodule

// File: verilog.f
+incdir+common
common/cache_pkg.sv
common/ring_pkg.sv
design/cache_array.sv
dcache/cache_datapath.sv
dcache/cache_ctrl.sv
dcache/dcache_top.sv
verification/tb_clock.sv
verification/ring_mem_model.sv
verification/dcache_tb.sv
